// ==== rtl/dnc_pkg.sv ====
// DNC write weighting package with fixed-point format, element structs and FSM states

package dnc_pkg;

  //////////////////////////////
  // Fixed-point format
  //////////////////////////////

  // Element width in bits
  localparam int DATA_WIDTH = 16;
  // Fraction bits, Q7.8
  localparam int FRAC_BITS  = 8;

  // Signed value for a, c, ga, gw and w
  typedef logic signed [DATA_WIDTH-1:0] fix_t;

  //////////////////////////////
  // Element structs
  //////////////////////////////

  // One popped pair of allocation and content elements
  typedef struct packed {
    fix_t a;
    fix_t c;
  } elem_pair_t;

  // Sideband of stages 1 and 2
  // c is still needed for the add in stage 3
  typedef struct packed {
    fix_t c;
    logic last;
  } diff_side_t;

  // Sideband of stages 3 and 4
  typedef struct packed {
    logic last;
  } last_side_t;

  //////////////////////////////
  // Controller states
  //////////////////////////////

  // IDLE waits for START, STREAM pops pairs, DRAIN empties the chain
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    STREAM = 2'd1,
    DRAIN  = 2'd2
  } wr_state_e;

endpackage

// ==== rtl/ntm_vector_adder.sv ====
// Element adder stage, one registered add or subtract with a sideband payload
`timescale 1ns/1ps

module ntm_vector_adder #(
  parameter bit  SUBTRACT = 1'b0,
  parameter type SIDE_T   = dnc_pkg::last_side_t
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           in_valid,
  input  dnc_pkg::fix_t  data_a,
  input  dnc_pkg::fix_t  data_b,
  input  SIDE_T          side_in,
  output logic           out_valid,
  output dnc_pkg::fix_t  data_out,
  output SIDE_T          side_out
);

  import dnc_pkg::*;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  fix_t result;

  // Both forms wrap at DATA_WIDTH bits
  assign result = SUBTRACT ? (data_a - data_b) : (data_a + data_b);

  //////////////////////////////
  // Stage register
  //////////////////////////////

  // Valid flag clears on reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Result and sideband load together
  // Held between elements, zero after reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out <= '0;
      side_out <= '0;
    end else if (in_valid) begin
      data_out <= result;
      side_out <= side_in;
    end
  end

endmodule

// ==== rtl/ntm_vector_multiplier.sv ====
// Element multiplier stage, one registered fixed-point product with a sideband payload
`timescale 1ns/1ps

module ntm_vector_multiplier #(
  parameter type SIDE_T = dnc_pkg::last_side_t
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           in_valid,
  input  dnc_pkg::fix_t  data_a,
  input  dnc_pkg::fix_t  data_b,
  input  SIDE_T          side_in,
  output logic           out_valid,
  output dnc_pkg::fix_t  data_out,
  output SIDE_T          side_out
);

  import dnc_pkg::*;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Full width product
  logic signed [2*DATA_WIDTH-1:0] product;
  // Product back in Q7.8
  logic signed [2*DATA_WIDTH-1:0] scaled;
  fix_t                           result;

  // Signed operands, so the product is sign extended
  assign product = data_a * data_b;

  // Arithmetic shift drops the extra fraction bits
  assign scaled = product >>> FRAC_BITS;

  // Truncate, no saturation
  assign result = scaled[DATA_WIDTH-1:0];

  //////////////////////////////
  // Stage register
  //////////////////////////////

  // Valid flag
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Result and sideband, updated only on a valid element
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out <= '0;
      side_out <= '0;
    end else if (in_valid) begin
      data_out <= result;
      side_out <= side_in;
    end
  end

endmodule

// ==== rtl/ntm_element_fifo.sv ====
// Element FIFO, small first-word fall-through buffer for one weighting stream
`timescale 1ns/1ps

module ntm_element_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           push,
  input  dnc_pkg::fix_t  push_data,
  input  logic           pop,
  output dnc_pkg::fix_t  pop_data,
  output logic           empty,
  output logic           full
);

  import dnc_pkg::*;

  // Pointer and occupancy widths
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  fix_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Accepted operations
  logic push_ok;
  logic pop_ok;

  assign push_ok = push & ~full;
  assign pop_ok  = pop & ~empty;

  // Status from occupancy
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(FIFO_DEPTH));

  // Oldest entry always on the output
  assign pop_data = mem[rd_ptr];

  // Storage write, no reset on the array
  always_ff @(posedge CLK) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

  //////////////////////////////
  // Pointer and count update
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at the last slot, depth need not be a power of two
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rtl/dnc_write_weighting.sv ====
// DNC write weighting controller, pairs a and c elements and runs the 4-stage chain
`timescale 1ns/1ps

module dnc_write_weighting #(
  parameter int SIZE_WIDTH = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  START,
  input  logic [SIZE_WIDTH-1:0] SIZE_N_IN,
  input  dnc_pkg::fix_t         GA_IN,
  input  dnc_pkg::fix_t         GW_IN,
  input  logic                  a_empty,
  input  logic                  a_full,
  input  dnc_pkg::fix_t         a_data,
  input  logic                  c_empty,
  input  logic                  c_full,
  input  dnc_pkg::fix_t         c_data,
  input  logic                  A_IN_ENABLE,
  input  logic                  C_IN_ENABLE,
  output logic                  a_push,
  output logic                  a_pop,
  output logic                  c_push,
  output logic                  c_pop,
  output logic                  A_OUT_ENABLE,
  output logic                  C_OUT_ENABLE,
  output logic                  W_OUT_ENABLE,
  output dnc_pkg::fix_t         W_OUT,
  output logic                  READY
);

  import dnc_pkg::*;

  // w(j) = gw * (c(j) + ga * (a(j) - c(j)))

  //////////////////////////////
  // Control state
  //////////////////////////////

  wr_state_e             state;
  logic [SIZE_WIDTH-1:0] size_q;
  logic [SIZE_WIDTH-1:0] count;
  // Gates held for the whole operation
  fix_t                  ga_q;
  fix_t                  gw_q;

  // Pairing
  logic       pop_fire;
  logic       last_elem;
  elem_pair_t pair;

  // Chain signals, sN is the output of stage N
  logic       s1_valid, s2_valid, s3_valid, s4_valid;
  fix_t       s1_data, s2_data, s3_data, s4_data;
  diff_side_t s1_side_in, s1_side, s2_side;
  last_side_t s3_side_in, s3_side, s4_side;

  // Producers may write only while streaming and not full
  assign A_OUT_ENABLE = (state == STREAM) & ~a_full;
  assign C_OUT_ENABLE = (state == STREAM) & ~c_full;

  // Strobes outside the enable window are dropped here
  assign a_push = A_IN_ENABLE & A_OUT_ENABLE;
  assign c_push = C_IN_ENABLE & C_OUT_ENABLE;

  // Pop both streams together once each holds an element
  assign pop_fire  = (state == STREAM) & ~a_empty & ~c_empty & (count < size_q);
  assign a_pop     = pop_fire;
  assign c_pop     = pop_fire;
  assign last_elem = (count == size_q - 1'b1);

  assign pair = '{a: a_data, c: c_data};

  // FSM, size capture and element counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= IDLE;
      size_q <= '0;
      count  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (START) begin
            size_q <= SIZE_N_IN;
            count  <= '0;
            state  <= STREAM;
          end
        end
        STREAM: begin
          if (pop_fire) begin
            count <= count + 1'b1;
            if (last_elem) begin
              state <= DRAIN;
            end
          end
        end
        DRAIN: begin
          // Last element entering stage 4, so IDLE coincides with READY
          if (s3_valid && s3_side.last) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Gate capture on an accepted START
  always_ff @(posedge CLK) begin
    if (state == IDLE && START) begin
      ga_q <= GA_IN;
      gw_q <= GW_IN;
    end
  end

  //////////////////////////////
  // Arithmetic chain
  //////////////////////////////

  assign s1_side_in = '{c: pair.c, last: last_elem};

  // Stage 1, a - c
  ntm_vector_adder #(
    .SUBTRACT (1'b1),
    .SIDE_T   (diff_side_t)
  ) diff_adder_i (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (pop_fire),
    .data_a    (pair.a),
    .data_b    (pair.c),
    .side_in   (s1_side_in),
    .out_valid (s1_valid),
    .data_out  (s1_data),
    .side_out  (s1_side)
  );

  // Stage 2, ga * (a - c)
  ntm_vector_multiplier #(
    .SIDE_T (diff_side_t)
  ) ga_mult_i (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (s1_valid),
    .data_a    (ga_q),
    .data_b    (s1_data),
    .side_in   (s1_side),
    .out_valid (s2_valid),
    .data_out  (s2_data),
    .side_out  (s2_side)
  );

  // c drops off the sideband here
  assign s3_side_in = '{last: s2_side.last};

  // Stage 3, c + scaled difference
  ntm_vector_adder #(
    .SUBTRACT (1'b0),
    .SIDE_T   (last_side_t)
  ) sum_adder_i (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (s2_valid),
    .data_a    (s2_side.c),
    .data_b    (s2_data),
    .side_in   (s3_side_in),
    .out_valid (s3_valid),
    .data_out  (s3_data),
    .side_out  (s3_side)
  );

  // Stage 4, gw * sum
  ntm_vector_multiplier #(
    .SIDE_T (last_side_t)
  ) gw_mult_i (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (s3_valid),
    .data_a    (gw_q),
    .data_b    (s3_data),
    .side_in   (s3_side),
    .out_valid (s4_valid),
    .data_out  (s4_data),
    .side_out  (s4_side)
  );

  // Outputs straight from the last stage, 4 cycles after the pop
  assign W_OUT_ENABLE = s4_valid;
  assign W_OUT        = s4_data;
  assign READY        = s4_valid & s4_side.last;

endmodule

// ==== rtl/dnc_write_top.sv ====
// DNC write weighting top, two stream FIFOs feeding the weighting controller
`timescale 1ns/1ps

module dnc_write_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int SIZE_WIDTH = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  START,
  input  logic [SIZE_WIDTH-1:0] SIZE_N_IN,
  input  dnc_pkg::fix_t         GA_IN,
  input  dnc_pkg::fix_t         GW_IN,
  input  logic                  A_IN_ENABLE,
  input  dnc_pkg::fix_t         A_IN,
  input  logic                  C_IN_ENABLE,
  input  dnc_pkg::fix_t         C_IN,
  output logic                  A_OUT_ENABLE,
  output logic                  C_OUT_ENABLE,
  output logic                  W_OUT_ENABLE,
  output dnc_pkg::fix_t         W_OUT,
  output logic                  READY
);

  import dnc_pkg::*;

  // Allocation stream FIFO side
  logic a_push, a_pop, a_empty, a_full;
  fix_t a_data;
  // Content stream FIFO side
  logic c_push, c_pop, c_empty, c_full;
  fix_t c_data;

  //////////////////////////////
  // Stream buffers
  //////////////////////////////

  ntm_element_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) a_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (a_push),
    .push_data (A_IN),
    .pop       (a_pop),
    .pop_data  (a_data),
    .empty     (a_empty),
    .full      (a_full)
  );

  ntm_element_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) c_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (c_push),
    .push_data (C_IN),
    .pop       (c_pop),
    .pop_data  (c_data),
    .empty     (c_empty),
    .full      (c_full)
  );

  //////////////////////////////
  // Weighting controller
  //////////////////////////////

  dnc_write_weighting #(
    .SIZE_WIDTH (SIZE_WIDTH)
  ) weighting_i (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .SIZE_N_IN    (SIZE_N_IN),
    .GA_IN        (GA_IN),
    .GW_IN        (GW_IN),
    .a_empty      (a_empty),
    .a_full       (a_full),
    .a_data       (a_data),
    .c_empty      (c_empty),
    .c_full       (c_full),
    .c_data       (c_data),
    .A_IN_ENABLE  (A_IN_ENABLE),
    .C_IN_ENABLE  (C_IN_ENABLE),
    .a_push       (a_push),
    .a_pop        (a_pop),
    .c_push       (c_push),
    .c_pop        (c_pop),
    .A_OUT_ENABLE (A_OUT_ENABLE),
    .C_OUT_ENABLE (C_OUT_ENABLE),
    .W_OUT_ENABLE (W_OUT_ENABLE),
    .W_OUT        (W_OUT),
    .READY        (READY)
  );

endmodule

// ==== testbench/dnc_write_tb.sv ====
// DNC write weighting testbench, streams a and c elements and checks W against a fixed-point model
`timescale 1ns/1ps

module dnc_write_tb;

  import dnc_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int SIZE_WIDTH = 8;
  // Elements over all operations below
  localparam int TOTAL_ELEMS    = 8 + 8 + 16 + 5 + 3 + 7;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_ELEMS + 200;

  logic                  CLK;
  logic                  RST;
  logic                  START;
  logic [SIZE_WIDTH-1:0] SIZE_N_IN;
  fix_t                  GA_IN, GW_IN, A_IN, C_IN, W_OUT;
  logic                  A_IN_ENABLE, C_IN_ENABLE;
  logic                  A_OUT_ENABLE, C_OUT_ENABLE, W_OUT_ENABLE, READY;

  // Stimulus and expected results of the running operation
  fix_t a_vals [32];
  fix_t c_vals [32];
  fix_t exp_q [$];
  fix_t exp_w;

  int errors, err_mark, checked, cycles;
  int outs_seen, ready_seen;

  dnc_write_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .SIZE_WIDTH (SIZE_WIDTH)
  ) dnc_write_top_i (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .SIZE_N_IN    (SIZE_N_IN),
    .GA_IN        (GA_IN),
    .GW_IN        (GW_IN),
    .A_IN_ENABLE  (A_IN_ENABLE),
    .A_IN         (A_IN),
    .C_IN_ENABLE  (C_IN_ENABLE),
    .C_IN         (C_IN),
    .A_OUT_ENABLE (A_OUT_ENABLE),
    .C_OUT_ENABLE (C_OUT_ENABLE),
    .W_OUT_ENABLE (W_OUT_ENABLE),
    .W_OUT        (W_OUT),
    .READY        (READY)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Q7.8 product, arithmetic shift then truncate
  function automatic fix_t fx_mul(input fix_t x, input fix_t y);
    logic signed [2*DATA_WIDTH-1:0] p;
    p = 32'(x) * 32'(y);
    p = p >>> FRAC_BITS;
    return p[DATA_WIDTH-1:0];
  endfunction

  // gw * (c + ga * (a - c)), sums wrap at 16 bits
  function automatic fix_t expected_weight(input fix_t a, input fix_t c,
                                           input fix_t ga, input fix_t gw);
    fix_t d;
    fix_t s;
    d = a - c;
    s = c + fx_mul(ga, d);
    return fx_mul(gw, s);
  endfunction

  // Gate in [0, 1.0]
  function automatic fix_t rand_gate();
    return fix_t'($urandom_range(256, 0));
  endfunction

  //////////////////////////////
  // Output checker
  //////////////////////////////

  // Mid-cycle sampling, outputs are settled here
  always @(negedge CLK) begin
    if (!RST) begin
      if (W_OUT_ENABLE) begin
        outs_seen++;
        checked++;
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: output strobe with no element pending", $time);
          errors++;
        end else begin
          exp_w = exp_q.pop_front();
          assert (W_OUT == exp_w) else begin
            $display("MISMATCH at %0t: W_OUT %h, expected %h", $time, W_OUT, exp_w);
            errors++;
          end
          // READY only with the final element
          assert (READY == (exp_q.size() == 0)) else begin
            $display("MISMATCH at %0t: READY %b on output %0d", $time, READY, outs_seen);
            errors++;
          end
        end
      end else begin
        assert (!READY) else begin
          $display("ERROR at %0t: READY pulsed without an output strobe", $time);
          errors++;
        end
      end
      if (READY) ready_seen++;
    end
  end

  // Watchdog
  always @(posedge CLK) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Sends elements first..last-1 of one stream, only while its enable is high
  task automatic send_stream(input bit is_c, input int first, input int last,
                             input int max_gap);
    int i;
    bit strobed;
    bit en;
    bit go;
    i = first;
    strobed = 1'b0;
    while (i < last) begin
      @(posedge CLK);
      en = is_c ? C_OUT_ENABLE : A_OUT_ENABLE;
      // A push may fill the FIFO, so never strobe twice in a row
      go = en && !strobed && ($urandom_range(max_gap, 0) == 0);
      if (is_c) begin
        C_IN_ENABLE <= go;
        C_IN        <= c_vals[i];
      end else begin
        A_IN_ENABLE <= go;
        A_IN        <= a_vals[i];
      end
      if (go) i++;
      strobed = go;
    end
    @(posedge CLK);
    if (is_c) begin
      C_IN_ENABLE <= 1'b0;
    end else begin
      A_IN_ENABLE <= 1'b0;
    end
  endtask

  // Mode 0 full model, 1 expects gw*a, 2 expects gw*c
  task automatic run_op(input int n, input fix_t ga, input fix_t gw, input int mode,
                        input int max_gap, input bit flood);
    int first_a;
    for (int i = 0; i < n; i++) begin
      a_vals[i] = fix_t'($urandom);
      c_vals[i] = fix_t'($urandom);
      case (mode)
        1:       exp_q.push_back(fx_mul(gw, a_vals[i]));
        2:       exp_q.push_back(fx_mul(gw, c_vals[i]));
        default: exp_q.push_back(expected_weight(a_vals[i], c_vals[i], ga, gw));
      endcase
    end
    outs_seen  = 0;
    ready_seen = 0;
    @(posedge CLK);
    START     <= 1'b1;
    SIZE_N_IN <= SIZE_WIDTH'(n);
    GA_IN     <= ga;
    GW_IN     <= gw;
    @(posedge CLK);
    START <= 1'b0;
    first_a = 0;
    if (flood) begin
      // a FIFO fills while the c stream holds back
      send_stream(1'b0, 0, FIFO_DEPTH, 0);
      first_a = FIFO_DEPTH;
      do @(posedge CLK); while (A_OUT_ENABLE);
      // Strobes into a full FIFO, no pops can free a slot yet
      repeat (3) begin
        A_IN_ENABLE <= 1'b1;
        A_IN        <= 16'sh7abc;
        @(posedge CLK);
        assert (!A_OUT_ENABLE) else begin
          $display("ERROR at %0t: A_OUT_ENABLE high with a full a FIFO", $time);
          errors++;
        end
      end
      A_IN_ENABLE <= 1'b0;
    end
    fork
      send_stream(1'b0, first_a, n, max_gap);
      send_stream(1'b1, 0, n, max_gap);
    join
    do @(posedge CLK); while (!READY);
    repeat (2) @(posedge CLK);
    assert (outs_seen == n && ready_seen == 1 && exp_q.size() == 0) else begin
      $display("ERROR at %0t: operation gave %0d outputs and %0d READY pulses for %0d elements",
               $time, outs_seen, ready_seen, n);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s finished, %0d error(s)", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(78));
    RST         = 1'b1;
    START       = 1'b0;
    SIZE_N_IN   = '0;
    GA_IN       = '0;
    GW_IN       = '0;
    A_IN_ENABLE = 1'b0;
    A_IN        = '0;
    C_IN_ENABLE = 1'b0;
    C_IN        = '0;
    errors      = 0;
    err_mark    = 0;
    checked     = 0;
    cycles      = 0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    // Idle after reset, stray strobes must be dropped
    A_IN_ENABLE <= 1'b1;
    A_IN        <= 16'sh1234;
    C_IN_ENABLE <= 1'b1;
    C_IN        <= 16'sh4321;
    repeat (6) begin
      @(posedge CLK);
      assert (!A_OUT_ENABLE && !C_OUT_ENABLE && !READY && !W_OUT_ENABLE) else begin
        $display("ERROR at %0t: outputs not low while idle after reset", $time);
        errors++;
      end
    end
    A_IN_ENABLE <= 1'b0;
    C_IN_ENABLE <= 1'b0;
    report_test(1, "reset and idle");

    run_op(8, 16'sd256, rand_gate(), 1, 1, 1'b0);
    report_test(2, "ga one");
    run_op(8, 16'sd0, rand_gate(), 2, 1, 1'b0);
    report_test(3, "ga zero");
    run_op(16, rand_gate(), rand_gate(), 0, 3, 1'b0);
    report_test(4, "random mix");
    // Back to back operations
    run_op(5, rand_gate(), rand_gate(), 0, 0, 1'b0);
    run_op(3, rand_gate(), rand_gate(), 0, 2, 1'b0);
    report_test(5, "completion");
    run_op(7, rand_gate(), rand_gate(), 0, 1, 1'b1);
    report_test(6, "flow control");

    $display("Summary: 6 tests, %0d outputs checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== dnc_write.f ====
rtl/dnc_pkg.sv
rtl/ntm_vector_adder.sv
rtl/ntm_vector_multiplier.sv
rtl/ntm_element_fifo.sv
rtl/dnc_write_weighting.sv
rtl/dnc_write_top.sv
testbench/dnc_write_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DNC write weighting testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module dnc_write_tb \
  -f dnc_write.f \
  -Mdir obj_dir -o dnc_write_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/dnc_write_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST FAILED ***" "$SIM_LOG"; then
  exit 1
fi
exit 0
